/* src/csc_settings.svh */
`ifndef CSC_SETTINGS_SVH
`define CSC_SETTINGS_SVH

// pixel and coefficient formats
`define CSC_PIX_W     8
`define CSC_COEF_W    17
`define CSC_FRAC_W    8
`define CSC_PROD_W    25
`define CSC_OFS_W     9
`define CSC_SYNC_W    3

// configuration space
`define CSC_NUM_REGS  12
`define CSC_ADDR_W    4

// pipeline depths in clock cycles
`define CSC_MUL_LAT   4
`define CSC_LAT       6

`define CSC_COEF_ONE  17'h00100

`endif

/* src/csc_pkg.sv */
`include "csc_settings.svh"

package csc_pkg;

  // sign-magnitude view with an 8.8 fixed point magnitude
  typedef struct packed {
    logic                    sign;
    logic [`CSC_COEF_W-2:0]  mag;
  } coef_sm_t;

  // the same coefficient word as written over the configuration port
  // and as split apart by the multiplier's Booth decode
  typedef union packed {
    logic [`CSC_COEF_W-1:0]  raw;
    coef_sm_t                sm;
  } coef_t;

endpackage

/* src/csc_coef_if.sv */
`include "csc_settings.svh"

interface csc_coef_if import csc_pkg::*; ();

  coef_t                          c1;  // weight of the r component
  coef_t                          c2;  // weight of the g component
  coef_t                          c3;  // weight of the b component
  logic signed [`CSC_OFS_W-1:0]   ofs;

  modport cfg (
    output c1,
    output c2,
    output c3,
    output ofs
  );

  modport chan (
    input  c1,
    input  c2,
    input  c3,
    input  ofs
  );

endinterface

/* src/csc_mul.sv */
`include "csc_settings.svh"

module csc_mul import csc_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  coef_t                   data_a,
  input  logic [`CSC_PIX_W-1:0]   data_b,
  output logic [`CSC_PROD_W-1:0]  data_p,
  input  logic [`CSC_SYNC_W-1:0]  sync_in,
  output logic [`CSC_SYNC_W-1:0]  sync_out
);

  localparam int MAG_W  = `CSC_PROD_W - 1;
  localparam int NUM_PP = `CSC_PIX_W / 2 + 1;  // extra group absorbs the top bit of unsigned b
  localparam int BEXT_W = 2 * NUM_PP + 1;

  logic [MAG_W-1:0]        mag_ext;
  logic [BEXT_W-1:0]       b_ext;

  logic                    p1_sign;
  logic [MAG_W-1:0]        p1_pp [NUM_PP];
  logic [`CSC_SYNC_W-1:0]  p1_sync;

  logic                    p2_sign;
  logic [MAG_W-1:0]        p2_sum0;
  logic [MAG_W-1:0]        p2_sum1;
  logic [`CSC_SYNC_W-1:0]  p2_sync;

  logic                    p3_sign;
  logic [MAG_W-1:0]        p3_mag;
  logic [`CSC_SYNC_W-1:0]  p3_sync;

  // radix-4 Booth digit selection of 0, +-1 or +-2 times the magnitude
  function automatic logic [MAG_W-1:0] booth_sel(
    input logic [2:0]       grp,
    input logic [MAG_W-1:0] mag
  );
    logic [MAG_W-1:0] neg;
    neg = ~mag + 1'b1;
    case (grp)
      3'b001, 3'b010: booth_sel = mag;
      3'b011:         booth_sel = mag << 1;
      3'b100:         booth_sel = neg << 1;
      3'b101, 3'b110: booth_sel = neg;
      default:        booth_sel = '0;
    endcase
  endfunction

  assign mag_ext = MAG_W'(data_a.sm.mag);

  // implied zero below bit 0 and zero padding above the top bit
  assign b_ext = {{(BEXT_W - `CSC_PIX_W - 1){1'b0}}, data_b, 1'b0};

  always_ff @(posedge clk) begin
    p1_sign <= data_a.sm.sign;
    for (int j = 0; j < NUM_PP; j++) begin
      p1_pp[j] <= booth_sel(b_ext[2*j +: 3], mag_ext) << (2 * j);
    end
  end

  always_ff @(posedge clk) begin
    p2_sign <= p1_sign;
    p2_sum0 <= p1_pp[0] + p1_pp[1] + p1_pp[NUM_PP-1];
    p2_sum1 <= p1_pp[2] + p1_pp[3];
  end

  always_ff @(posedge clk) begin
    p3_sign <= p2_sign;
    p3_mag  <= p2_sum0 + p2_sum1;  // modulo 2^24 wraps the negative digits away
  end

  always_ff @(posedge clk) begin
    data_p <= {p3_sign, p3_mag};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1_sync  <= '0;
      p2_sync  <= '0;
      p3_sync  <= '0;
      sync_out <= '0;
    end else begin
      p1_sync  <= sync_in;
      p2_sync  <= p1_sync;
      p3_sync  <= p2_sync;
      sync_out <= p3_sync;
    end
  end

  // strobes must come out exactly as many cycles late as the product
  a_sync_delay : assert property (
    @(posedge clk)
    rst_n [*(`CSC_MUL_LAT + 1)] |-> sync_out == $past(sync_in, `CSC_MUL_LAT)
  ) else $error("csc_mul sideband out of step with the data pipeline");

endmodule

/* src/csc_channel.sv */
`include "csc_settings.svh"

module csc_channel import csc_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`CSC_PIX_W-1:0]   pix_r,
  input  logic [`CSC_PIX_W-1:0]   pix_g,
  input  logic [`CSC_PIX_W-1:0]   pix_b,
  input  logic [`CSC_SYNC_W-1:0]  sync_in,
  csc_coef_if.chan                coef,
  output logic [`CSC_PIX_W-1:0]   comp,
  output logic [`CSC_SYNC_W-1:0]  sync_out
);

  localparam int SUM_W = `CSC_PROD_W + 2;  // three signed products cannot overflow this

  logic [`CSC_PROD_W-1:0]   prod_r;
  logic [`CSC_PROD_W-1:0]   prod_g;
  logic [`CSC_PROD_W-1:0]   prod_b;
  logic [`CSC_SYNC_W-1:0]   mul_sync;

  logic signed [SUM_W-1:0]  s5_sum;
  logic [`CSC_SYNC_W-1:0]   s5_sync;

  logic signed [SUM_W-1:0]  ofs_ext;
  logic signed [SUM_W-1:0]  scaled;

  function automatic logic signed [SUM_W-1:0] to_signed(input logic [`CSC_PROD_W-1:0] p);
    logic signed [SUM_W-1:0] mag;
    mag = {{(SUM_W - `CSC_PROD_W + 1){1'b0}}, p[`CSC_PROD_W-2:0]};
    to_signed = p[`CSC_PROD_W-1] ? -mag : mag;
  endfunction

  csc_mul mul_r (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_a   (coef.c1),
    .data_b   (pix_r),
    .data_p   (prod_r),
    .sync_in  (sync_in),
    .sync_out (mul_sync)
  );

  csc_mul mul_g (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_a   (coef.c2),
    .data_b   (pix_g),
    .data_p   (prod_g),
    .sync_in  (sync_in),
    .sync_out ()
  );

  csc_mul mul_b (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_a   (coef.c3),
    .data_b   (pix_b),
    .data_p   (prod_b),
    .sync_in  (sync_in),
    .sync_out ()
  );

  always_ff @(posedge clk) begin
    s5_sum <= to_signed(prod_r) + to_signed(prod_g) + to_signed(prod_b);
  end

  assign ofs_ext = coef.ofs;  // sign extends
  assign scaled  = (s5_sum >>> `CSC_FRAC_W) + ofs_ext;  // floor toward minus infinity

  always_ff @(posedge clk) begin
    if (scaled[SUM_W-1]) begin
      comp <= '0;
    end else if (|scaled[SUM_W-2:`CSC_PIX_W]) begin
      comp <= '1;
    end else begin
      comp <= scaled[`CSC_PIX_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s5_sync  <= '0;
      sync_out <= '0;
    end else begin
      s5_sync  <= mul_sync;
      sync_out <= s5_sync;
    end
  end

endmodule

/* src/csc_coef_regs.sv */
`include "csc_settings.svh"

module csc_coef_regs import csc_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cfg_wr,
  input  logic [`CSC_ADDR_W-1:0]  cfg_addr,
  input  logic [`CSC_COEF_W-1:0]  cfg_wdata,
  csc_coef_if.cfg                 ch0,
  csc_coef_if.cfg                 ch1,
  csc_coef_if.cfg                 ch2
);

  localparam int NUM_CH = `CSC_NUM_REGS / 4;

  coef_t                         coef_q [NUM_CH][3];
  logic signed [`CSC_OFS_W-1:0]  ofs_q  [NUM_CH];

  logic [1:0]                    wr_ch;
  logic [1:0]                    wr_sel;

  assign wr_ch  = cfg_addr[3:2];
  assign wr_sel = cfg_addr[1:0];  // 3 picks the offset

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < NUM_CH; n++) begin
        for (int k = 0; k < 3; k++) begin
          coef_q[n][k].raw <= (n == k) ? `CSC_COEF_ONE : '0;  // identity matrix
        end
        ofs_q[n] <= '0;
      end
    end else if (cfg_wr && wr_ch < NUM_CH) begin
      if (wr_sel == 2'd3) begin
        ofs_q[wr_ch] <= cfg_wdata[`CSC_OFS_W-1:0];
      end else begin
        coef_q[wr_ch][wr_sel].raw <= cfg_wdata;
      end
    end
  end

  assign ch0.c1  = coef_q[0][0];
  assign ch0.c2  = coef_q[0][1];
  assign ch0.c3  = coef_q[0][2];
  assign ch0.ofs = ofs_q[0];

  assign ch1.c1  = coef_q[1][0];
  assign ch1.c2  = coef_q[1][1];
  assign ch1.c3  = coef_q[1][2];
  assign ch1.ofs = ofs_q[1];

  assign ch2.c1  = coef_q[2][0];
  assign ch2.c2  = coef_q[2][1];
  assign ch2.c3  = coef_q[2][2];
  assign ch2.ofs = ofs_q[2];

  // such a write is dropped, so the host's view of the bank would go stale
  a_addr_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_wr |-> cfg_addr < `CSC_NUM_REGS
  ) else $error("csc_coef_regs write to unmapped address %0d", cfg_addr);

endmodule

/* src/csc_top.sv */
`include "csc_settings.svh"

module csc_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_de,
  input  logic                    in_hs,
  input  logic                    in_vs,
  input  logic [`CSC_PIX_W-1:0]   in_r,
  input  logic [`CSC_PIX_W-1:0]   in_g,
  input  logic [`CSC_PIX_W-1:0]   in_b,
  input  logic                    cfg_wr,
  input  logic [`CSC_ADDR_W-1:0]  cfg_addr,
  input  logic [`CSC_COEF_W-1:0]  cfg_wdata,
  output logic                    out_de,
  output logic                    out_hs,
  output logic                    out_vs,
  output logic [`CSC_PIX_W-1:0]   out_c0,
  output logic [`CSC_PIX_W-1:0]   out_c1,
  output logic [`CSC_PIX_W-1:0]   out_c2
);

  csc_coef_if coef0 ();
  csc_coef_if coef1 ();
  csc_coef_if coef2 ();

  csc_coef_regs regs0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .ch0       (coef0.cfg),
    .ch1       (coef1.cfg),
    .ch2       (coef2.cfg)
  );

  csc_channel chan0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_r    (in_r),
    .pix_g    (in_g),
    .pix_b    (in_b),
    .sync_in  ({in_de, in_hs, in_vs}),
    .coef     (coef0.chan),
    .comp     (out_c0),
    .sync_out ({out_de, out_hs, out_vs})  // one copy of the strobes is enough
  );

  csc_channel chan1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_r    (in_r),
    .pix_g    (in_g),
    .pix_b    (in_b),
    .sync_in  ({in_de, in_hs, in_vs}),
    .coef     (coef1.chan),
    .comp     (out_c1),
    .sync_out ()
  );

  csc_channel chan2 (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix_r    (in_r),
    .pix_g    (in_g),
    .pix_b    (in_b),
    .sync_in  ({in_de, in_hs, in_vs}),
    .coef     (coef2.chan),
    .comp     (out_c2),
    .sync_out ()
  );

endmodule

/* verif/csc_clkgen.sv */
module csc_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 5;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;  // released on a rising edge like any other input
  end

endmodule

/* verif/csc_tb.sv */
`include "csc_settings.svh"

module csc_tb;

  localparam int TIMEOUT_CYCLES = 3000;  // six tests of under 400 cycles each

  logic                    clk;
  logic                    rst_n;
  logic                    in_de;
  logic                    in_hs;
  logic                    in_vs;
  logic [`CSC_PIX_W-1:0]   in_r;
  logic [`CSC_PIX_W-1:0]   in_g;
  logic [`CSC_PIX_W-1:0]   in_b;
  logic                    cfg_wr;
  logic [`CSC_ADDR_W-1:0]  cfg_addr;
  logic [`CSC_COEF_W-1:0]  cfg_wdata;
  logic                    out_de;
  logic                    out_hs;
  logic                    out_vs;
  logic [`CSC_PIX_W-1:0]   out_comp [3];

  int                      seed = 32'h3b464978;
  int                      err_count = 0;
  int                      pass_tests = 0;
  int                      fail_tests = 0;
  int                      cycle_count = 0;
  logic                    strobe_seen = 1'b0;

  logic [`CSC_COEF_W-1:0]  shadow_coef [3][3];
  logic [`CSC_OFS_W-1:0]   shadow_ofs [3];
  logic [`CSC_PIX_W-1:0]   exp_pipe [`CSC_LAT][3];  // expected components with one row per cycle

  csc_clkgen clkgen0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  csc_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_de     (in_de),
    .in_hs     (in_hs),
    .in_vs     (in_vs),
    .in_r      (in_r),
    .in_g      (in_g),
    .in_b      (in_b),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .out_de    (out_de),
    .out_hs    (out_hs),
    .out_vs    (out_vs),
    .out_c0    (out_comp[0]),
    .out_c1    (out_comp[1]),
    .out_c2    (out_comp[2])
  );

  // weighted sum of r, g, b, floor shift, offset, clamp to 0..255
  function automatic logic [`CSC_PIX_W-1:0] expect_comp(
    input int                    n,
    input logic [`CSC_PIX_W-1:0] r,
    input logic [`CSC_PIX_W-1:0] g,
    input logic [`CSC_PIX_W-1:0] b
  );
    logic [`CSC_PIX_W-1:0] pix [3];
    longint                acc;
    longint                term;
    pix[0] = r;
    pix[1] = g;
    pix[2] = b;
    acc = 0;
    for (int k = 0; k < 3; k++) begin
      term = longint'(shadow_coef[n][k][`CSC_COEF_W-2:0]) * longint'(pix[k]);
      if (shadow_coef[n][k][`CSC_COEF_W-1]) begin
        term = -term;
      end
      acc = acc + term;
    end
    acc = (acc >>> `CSC_FRAC_W) + longint'($signed(shadow_ofs[n]));
    if (acc < 0) begin
      expect_comp = '0;
    end else if (acc > 255) begin
      expect_comp = '1;
    end else begin
      expect_comp = acc[`CSC_PIX_W-1:0];
    end
  endfunction

  always @(posedge clk) begin
    for (int n = 0; n < 3; n++) begin
      exp_pipe[0][n] <= expect_comp(n, in_r, in_g, in_b);
      for (int s = 1; s < `CSC_LAT; s++) begin
        exp_pipe[s][n] <= exp_pipe[s-1][n];
      end
    end
    if (in_de || in_hs || in_vs) begin
      strobe_seen <= 1'b1;
    end
  end

  a_quiet_after_reset : assert property (
    @(posedge clk) disable iff (!rst_n)
    !strobe_seen |-> !out_de && !out_hs && !out_vs
  ) else begin
    err_count++;
    $display("CHECK FAILED at time %0t: output strobe high before any input strobe", $time);
  end

  a_strobe_align : assert property (
    @(posedge clk) disable iff (!rst_n)
    {out_de, out_hs, out_vs} == $past({in_de, in_hs, in_vs}, `CSC_LAT)
  ) else begin
    err_count++;
    $display("CHECK FAILED at time %0t: strobes not delayed by %0d cycles", $time, `CSC_LAT);
  end

  for (genvar n = 0; n < 3; n++) begin : g_comp_check
    a_comp : assert property (
      @(posedge clk) disable iff (!rst_n)
      out_de |-> out_comp[n] == exp_pipe[`CSC_LAT-1][n]
    ) else begin
      err_count++;
      $display("CHECK FAILED at time %0t: channel %0d output differs from expected value",
               $time, n);
    end
  end

  function automatic logic [`CSC_PIX_W-1:0] rand8();
    int v;
    v = $random(seed);
    return v[`CSC_PIX_W-1:0];
  endfunction

  function automatic logic one_in(input int ratio);
    int v;
    v = $random(seed);
    return ((v & 32'h7fffffff) % ratio) == 0;
  endfunction

  function automatic logic [`CSC_COEF_W-1:0] rand_coef(input logic [15:0] mag_mask);
    int v;
    v = $random(seed);
    return {v[16], v[15:0] & mag_mask};
  endfunction

  task automatic drive_cycle(input logic de, input logic hs, input logic vs);
    @(posedge clk);
    in_de <= de;
    in_hs <= hs;
    in_vs <= vs;
    in_r  <= rand8();
    in_g  <= rand8();
    in_b  <= rand8();
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) drive_cycle(1'b0, 1'b0, 1'b0);
  endtask

  task automatic write_reg(input logic [`CSC_ADDR_W-1:0] addr, input logic [16:0] data);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    if (addr[1:0] == 2'd3) begin
      shadow_ofs[addr[3:2]] <= data[`CSC_OFS_W-1:0];
    end else begin
      shadow_coef[addr[3:2]][addr[1:0]] <= data;
    end
    @(posedge clk);
    cfg_wr <= 1'b0;
  endtask

  task automatic write_channel(input int n, input logic [16:0] c1, input logic [16:0] c2,
                               input logic [16:0] c3, input logic [8:0] ofs);
    write_reg(4'(4 * n), c1);
    write_reg(4'(4 * n + 1), c2);
    write_reg(4'(4 * n + 2), c3);
    write_reg(4'(4 * n + 3), 17'(ofs));
  endtask

  task automatic finish_test(input int num, input string name, input int errs_before);
    idle_cycles(`CSC_LAT + 2);  // lets the last pixels reach the checks
    if (err_count == errs_before) begin
      pass_tests++;
      $display("test %0d %s: passed", num, name);
    end else begin
      fail_tests++;
      $display("test %0d %s: failed", num, name);
    end
  endtask

  initial begin
    int errs;
    in_de     <= 1'b0;
    in_hs     <= 1'b0;
    in_vs     <= 1'b0;
    in_r      <= '0;
    in_g      <= '0;
    in_b      <= '0;
    cfg_wr    <= 1'b0;
    cfg_addr  <= '0;
    cfg_wdata <= '0;
    for (int n = 0; n < 3; n++) begin
      for (int k = 0; k < 3; k++) begin
        shadow_coef[n][k] = (n == k) ? `CSC_COEF_ONE : '0;
      end
      shadow_ofs[n] = '0;
    end
    while (rst_n !== 1'b1) @(posedge clk);

    errs = err_count;
    idle_cycles(20);
    finish_test(1, "quiet strobes after reset", errs);

    errs = err_count;
    for (int i = 0; i < 200; i++) drive_cycle(1'b1, one_in(16), one_in(32));
    finish_test(2, "bypass passes pixels unchanged", errs);

    errs = err_count;
    for (int n = 0; n < 3; n++) begin
      write_channel(n, (n == 0) ? 17'h00100 : 17'h100c0, (n == 1) ? 17'h00100 : 17'h100c0,
                    (n == 2) ? 17'h00100 : 17'h100c0, 9'd0);
    end
    for (int i = 0; i < 150; i++) drive_cycle(1'b1, 1'b0, 1'b0);
    finish_test(3, "negative results clamp to zero", errs);

    errs = err_count;
    for (int n = 0; n < 3; n++) begin
      write_channel(n, (n == 0) ? 17'h00180 : 17'h00040, (n == 1) ? 17'h00180 : 17'h00040,
                    (n == 2) ? 17'h00180 : 17'h00040, 9'd40);
    end
    for (int i = 0; i < 150; i++) drive_cycle(1'b1, 1'b0, 1'b0);
    finish_test(4, "large results saturate at 255", errs);

    errs = err_count;
    for (int round = 0; round < 2; round++) begin
      for (int n = 0; n < 3; n++) begin
        write_channel(n, rand_coef(round ? 16'h00ff : 16'h03ff),
                      rand_coef(round ? 16'h00ff : 16'h03ff),
                      rand_coef(round ? 16'h00ff : 16'h03ff), 9'(rand8() * 2 + one_in(2)));
      end
      for (int i = 0; i < 100; i++) drive_cycle(1'b1, 1'b0, 1'b0);
      idle_cycles(`CSC_LAT + 2);  // drained before the next coefficient set
    end
    finish_test(5, "random coefficients and offsets", errs);

    errs = err_count;
    for (int i = 0; i < 300; i++) begin
      drive_cycle((i % 50) < 40, one_in(7), (i >= 120 && i < 124) || i == 233);
    end
    finish_test(6, "strobes stay aligned with data", errs);

    $display("tests passed: %0d, tests failed: %0d, check failures: %0d",
             pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run timed out after %0d cycles", cycle_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* csc_top.f */
+incdir+src
src/csc_pkg.sv
src/csc_coef_if.sv
src/csc_mul.sv
src/csc_channel.sv
src/csc_coef_regs.sv
src/csc_top.sv
verif/csc_clkgen.sv
verif/csc_tb.sv
